// ==== hdl/etx_pkg.sv ====
package etx_pkg;

   // Packet kind, carried in header byte bits 5:4
   typedef enum logic [1:0]
   {
      cmd_write = 2'd0,                            // Remote write request
      cmd_read  = 2'd1,                            // Remote read request
      cmd_rresp = 2'd2                             // Read response
   } etx_cmd_t;

   // Field order matches the byte order on the link
   typedef struct packed
   {
      etx_cmd_t    cmd;                            // Header bits 5:4
      logic [3:0]  ctrlmode;                       // Header bits 3:0
      logic [31:0] dst_addr;                       // Bytes 1-4, MSB first
      logic [31:0] data;                           // Bytes 5-8
      logic [31:0] src_addr;                       // Bytes 9-12
   } etx_packet_t;

   // Burst layout
   localparam int PKT_BYTES  = 13;                 // Header plus three words
   localparam int PKT_BITS   = PKT_BYTES * 8;      // Shift register width
   localparam int BYTE_CNT_W = $clog2(PKT_BYTES);  // Byte counter width

   // Chip ID field inside dst_addr
   localparam int ID_MSB = 31;
   localparam int ID_LSB = 20;

   // Packet queues
   localparam int FIFO_DEPTH = 8;                  // Entries per queue
   localparam int FIFO_AW    = $clog2(FIFO_DEPTH); // Pointer width
   localparam int FIFO_AFULL = 6;                  // Wait threshold

endpackage

// ==== hdl/etx_regs_pkg.sv ====
package etx_regs_pkg;

   // Word address, taken from mi_addr[3:2]
   typedef enum logic [1:0]
   {
      reg_cfg    = 2'd0,                           // 0x0 enable, bypass, ctrlmode
      reg_id     = 2'd1,                           // 0x4 chip ID
      reg_status = 2'd2                            // 0x8 status, read only
   } etx_reg_t;

   localparam int REG_ADDR_MSB = 3;
   localparam int REG_ADDR_LSB = 2;

   // reg_cfg fields
   localparam int CFG_EN_BIT = 0;
   localparam int CFG_BP_BIT = 1;
   localparam int CFG_CM_MSB = 7;
   localparam int CFG_CM_LSB = 4;
   localparam int ID_W       = 12;                 // reg_id bits 11:0

   // reg_status fields
   localparam int ST_FULL_MSB = 2;                 // rr, rd, wr full
   localparam int ST_FULL_LSB = 0;
   localparam int ST_OVF_MSB  = 5;                 // rr, rd, wr overflow
   localparam int ST_OVF_LSB  = 3;
   localparam int ST_ACCESS   = 6;                 // Packet held by arbiter

   typedef struct packed
   {
      logic            enable;                     // Arbiter may select
      logic            ctrlmode_bp;                // Replace packet ctrlmode
      logic [3:0]      ctrlmode;                   // Replacement value
      logic [ID_W-1:0] chip_id;                    // Own chip ID
   } etx_cfg_t;

   localparam etx_cfg_t CFG_RESET = '{enable: 1'b0, ctrlmode_bp: 1'b0,
                                      ctrlmode: 4'h0, chip_id: '0};

endpackage

// ==== hdl/etx_cfg.sv ====
`timescale 1ns/1ps

module etx_cfg import etx_regs_pkg::*;
(
   input  logic        mi_clk,
   input  logic        rst,
   input  logic        mi_en,
   input  logic        mi_we,
   input  logic [19:0] mi_addr,
   input  logic [31:0] mi_din,
   input  logic [31:0] status,                     // Full, overflow pulses, access
   output logic [31:0] mi_dout,
   output etx_cfg_t    cfg
);

   etx_reg_t    reg_addr;                          // Decoded word address
   logic        wr_en;                             // Register write strobe
   logic        rd_en;                             // Register read strobe
   logic [2:0]  ovf_q;                             // Sticky overflow flags
   logic [31:0] rd_data;                           // Readback mux

   assign reg_addr = etx_reg_t'(mi_addr[REG_ADDR_MSB:REG_ADDR_LSB]);
   assign wr_en    = mi_en & mi_we;
   assign rd_en    = mi_en & ~mi_we;

   always_ff @(posedge mi_clk)
   begin
      if (rst)
         cfg <= CFG_RESET;
      else if (wr_en && reg_addr == reg_cfg)
      begin
         cfg.enable      <= mi_din[CFG_EN_BIT];
         cfg.ctrlmode_bp <= mi_din[CFG_BP_BIT];
         cfg.ctrlmode    <= mi_din[CFG_CM_MSB:CFG_CM_LSB];
      end
      else if (wr_en && reg_addr == reg_id)
         cfg.chip_id <= mi_din[ID_W-1:0];
   end

   // New overflow pulses win over a clear in the same cycle
   always_ff @(posedge mi_clk)
   begin
      if (rst)
         ovf_q <= 3'b000;
      else if (wr_en && reg_addr == reg_status)
         ovf_q <= (ovf_q & ~mi_din[ST_OVF_MSB:ST_OVF_LSB]) | status[ST_OVF_MSB:ST_OVF_LSB];
      else
         ovf_q <= ovf_q | status[ST_OVF_MSB:ST_OVF_LSB];
   end

   always_comb
   begin
      case (reg_addr)
         reg_cfg:    rd_data = {24'h0, cfg.ctrlmode, 2'b00, cfg.ctrlmode_bp, cfg.enable};
         reg_id:     rd_data = {{(32-ID_W){1'b0}}, cfg.chip_id};
         reg_status: rd_data = {25'h0, status[ST_ACCESS], ovf_q,
                                status[ST_FULL_MSB:ST_FULL_LSB]};
         default:    rd_data = 32'h0;              // Unmapped word
      endcase
   end

   always_ff @(posedge mi_clk)
   begin
      if (rst)
         mi_dout <= 32'h0;
      else if (rd_en)
         mi_dout <= rd_data;                       // Valid one cycle after mi_en
   end

endmodule

// ==== hdl/etx_fifo.sv ====
`timescale 1ns/1ps

module etx_fifo import etx_pkg::*;
(
   input  logic        mi_clk,
   input  logic        rst,
   input  logic        wr,                         // Push strobe
   input  etx_packet_t din,
   input  logic        rd,                         // Pop strobe
   output etx_packet_t dout,                       // Head packet
   output logic        empty,
   output logic        full,
   output logic        almost_full,                // Source must stop
   output logic        overflow                    // Lost push
);

   etx_packet_t        mem [FIFO_DEPTH];           // Packet storage
   logic [FIFO_AW-1:0] wr_ptr;
   logic [FIFO_AW-1:0] rd_ptr;
   logic [FIFO_AW:0]   count;                      // Entries held
   logic               push;
   logic               pop;

   assign push = wr & ~full;
   assign pop  = rd & ~empty;

   always_ff @(posedge mi_clk)
   begin
      if (push)
         mem[wr_ptr] <= din;
   end

   always_ff @(posedge mi_clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;               // Wraps at depth
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;
      end
   end

   assign dout        = mem[rd_ptr];               // Head visible after the write edge
   assign empty       = (count == '0);
   assign full        = (count == (FIFO_AW+1)'(FIFO_DEPTH));
   assign almost_full = (count >= (FIFO_AW+1)'(FIFO_AFULL));
   assign overflow    = wr & full;                 // One pulse per lost strobe

endmodule

// ==== hdl/etx_arbiter.sv ====
`timescale 1ns/1ps

module etx_arbiter import etx_pkg::*, etx_regs_pkg::*;
(
   input  logic        mi_clk,
   input  logic        rst,
   input  etx_cfg_t    cfg,
   input  logic        wr_empty,
   input  logic        rd_empty,
   input  logic        rr_empty,
   input  etx_packet_t wr_head,
   input  etx_packet_t rd_head,
   input  etx_packet_t rr_head,
   input  logic        txi_wr_wait,                // Remote write push-back
   input  logic        txi_rd_wait,                // Remote read push-back
   input  logic        etx_ack,                    // Protocol took the packet
   output logic        wr_pop,
   output logic        rd_pop,
   output logic        rr_pop,
   output logic        etx_access,
   output etx_packet_t etx_packet
);

   logic        can_sel;                           // Free to pick a new packet
   logic        wr_ok;
   logic        rd_ok;
   logic        rr_ok;
   etx_packet_t sel_pkt;                           // Winner before override

   // Push-back gates new selections only
   assign wr_ok   = ~wr_empty & ~txi_wr_wait;
   assign rd_ok   = ~rd_empty & ~txi_rd_wait;
   assign rr_ok   = ~rr_empty & ~txi_wr_wait;     // Responses travel as writes
   assign can_sel = cfg.enable & ~etx_access;

   assign rr_pop = can_sel & rr_ok;                // Highest priority
   assign rd_pop = can_sel & rd_ok & ~rr_ok;
   assign wr_pop = can_sel & wr_ok & ~rr_ok & ~rd_ok;

   always_comb
   begin
      if (rr_ok)
         sel_pkt = rr_head;
      else if (rd_ok)
         sel_pkt = rd_head;
      else
         sel_pkt = wr_head;
      if (cfg.ctrlmode_bp)
         sel_pkt.ctrlmode = cfg.ctrlmode;          // Config overrides packet
   end

   always_ff @(posedge mi_clk)
   begin
      if (rst)
         etx_access <= 1'b0;
      else if (rr_pop || rd_pop || wr_pop)
         etx_access <= 1'b1;                       // Rises one cycle after pop
      else if (etx_ack)
         etx_access <= 1'b0;
   end

   always_ff @(posedge mi_clk)
   begin
      if (rr_pop || rd_pop || wr_pop)
         etx_packet <= sel_pkt;                    // Held until ack
   end

endmodule

// ==== hdl/etx_protocol.sv ====
`timescale 1ns/1ps

module etx_protocol import etx_pkg::*;
(
   input  logic        mi_clk,
   input  logic        rst,
   input  logic        etx_access,                 // Packet waiting
   input  etx_packet_t etx_packet,
   output logic        etx_ack,                    // Packet latched
   output logic        txo_frame,                  // High for the whole burst
   output logic [7:0]  txo_data                    // One byte per cycle
);

   typedef enum logic [1:0]
   {
      st_idle = 2'd0,                              // Ready for a packet
      st_send = 2'd1,                              // Bytes on the link
      st_gap  = 2'd2                               // Idle cycle between bursts
   } etx_state_t;

   etx_state_t            state;
   logic [BYTE_CNT_W-1:0] byte_cnt;                // Byte being sent
   logic [PKT_BITS-1:0]   shreg;                   // Burst bytes, header on top
   logic                  last_byte;

   assign etx_ack   = (state == st_idle) & etx_access;
   assign last_byte = (byte_cnt == BYTE_CNT_W'(PKT_BYTES - 1));

   always_ff @(posedge mi_clk)
   begin
      if (rst)
      begin
         state    <= st_idle;
         byte_cnt <= '0;
      end
      else
      begin
         case (state)
            st_idle:
            begin
               byte_cnt <= '0;
               if (etx_ack)
                  state <= st_send;                // Burst starts next cycle
            end
            st_send:
            begin
               byte_cnt <= byte_cnt + 1'b1;
               if (last_byte)
                  state <= st_gap;
            end
            st_gap:
            begin
               byte_cnt <= '0;
               state    <= st_idle;
            end
            default:
            begin
               byte_cnt <= '0;
               state    <= st_idle;
            end
         endcase
      end
   end

   // Header byte, then dst_addr, data, src_addr, each MSB first
   always_ff @(posedge mi_clk)
   begin
      if (etx_ack)
         shreg <= {2'b00, etx_packet.cmd, etx_packet.ctrlmode,
                   etx_packet.dst_addr, etx_packet.data, etx_packet.src_addr};
      else if (state == st_send)
         shreg <= shreg << 8;                      // Next byte to the top
   end

   assign txo_frame = (state == st_send);
   assign txo_data  = txo_frame ? shreg[PKT_BITS-1 -: 8] : 8'h00; // Quiet between bursts

endmodule

// ==== hdl/etx.sv ====
`timescale 1ns/1ps

module etx import etx_pkg::*, etx_regs_pkg::*;
(
   input  logic        mi_clk,
   input  logic        rst,
   input  logic        mi_en,
   input  logic        mi_we,
   input  logic [19:0] mi_addr,
   input  logic [31:0] mi_din,
   output logic [31:0] mi_dout,
   input  logic        txwr_access,                // Write request strobe
   input  etx_packet_t txwr_packet,
   output logic        txwr_wait,
   input  logic        txrd_access,                // Read request strobe
   input  etx_packet_t txrd_packet,
   output logic        txrd_wait,
   input  logic        txrr_access,                // Read response strobe
   input  etx_packet_t txrr_packet,
   output logic        txrr_wait,
   input  logic        txi_wr_wait,
   input  logic        txi_rd_wait,
   output logic        txo_frame,
   output logic [7:0]  txo_data
);

   etx_cfg_t    cfg;
   logic [31:0] status;                            // Fed to reg_status
   logic        txwr_push, txrd_push;              // After chip ID drop
   logic        txwr_empty, txrd_empty, txrr_empty;
   logic        txwr_full, txrd_full, txrr_full;
   logic        txwr_ovf, txrd_ovf, txrr_ovf;      // Lost strobe pulses
   logic        txwr_pop, txrd_pop, txrr_pop;
   etx_packet_t txwr_head, txrd_head, txrr_head;
   logic        etx_access, etx_ack;
   etx_packet_t etx_packet;                        // Packet held by arbiter

   // Requests addressed to this chip never enter a queue
   assign txwr_push = txwr_access & (txwr_packet.dst_addr[ID_MSB:ID_LSB] != cfg.chip_id);
   assign txrd_push = txrd_access & (txrd_packet.dst_addr[ID_MSB:ID_LSB] != cfg.chip_id);

   assign status = {25'h0, etx_access, txrr_ovf, txrd_ovf, txwr_ovf,
                    txrr_full, txrd_full, txwr_full};

   etx_cfg cfg0 (.mi_clk, .rst, .mi_en, .mi_we, .mi_addr, .mi_din, .status, .mi_dout, .cfg);

   etx_fifo txwr_fifo (.mi_clk, .rst, .wr(txwr_push), .din(txwr_packet), .rd(txwr_pop),
                       .dout(txwr_head), .empty(txwr_empty), .full(txwr_full),
                       .almost_full(txwr_wait), .overflow(txwr_ovf));

   etx_fifo txrd_fifo (.mi_clk, .rst, .wr(txrd_push), .din(txrd_packet), .rd(txrd_pop),
                       .dout(txrd_head), .empty(txrd_empty), .full(txrd_full),
                       .almost_full(txrd_wait), .overflow(txrd_ovf));

   etx_fifo txrr_fifo (.mi_clk, .rst, .wr(txrr_access), .din(txrr_packet), .rd(txrr_pop),
                       .dout(txrr_head), .empty(txrr_empty), .full(txrr_full),
                       .almost_full(txrr_wait), .overflow(txrr_ovf));

   etx_arbiter arb0 (.mi_clk, .rst, .cfg,
                     .wr_empty(txwr_empty), .rd_empty(txrd_empty), .rr_empty(txrr_empty),
                     .wr_head(txwr_head), .rd_head(txrd_head), .rr_head(txrr_head),
                     .txi_wr_wait, .txi_rd_wait, .etx_ack,
                     .wr_pop(txwr_pop), .rd_pop(txrd_pop), .rr_pop(txrr_pop),
                     .etx_access, .etx_packet);

   etx_protocol proto0 (.mi_clk, .rst, .etx_access, .etx_packet, .etx_ack,
                        .txo_frame, .txo_data);

endmodule

// ==== verif/etx_chk.sv ====
`timescale 1ns/1ps

module etx_chk import etx_pkg::*;
(
   input logic mi_clk,
   input logic rst,
   input logic txo_frame,
   input logic etx_ack,
   input logic etx_access,
   input logic txwr_pop,
   input logic txrd_pop,
   input logic txrr_pop
);

   int assert_fails = 0;                           // Read by the testbench at the end

   a_frame_len: assert property (@(posedge mi_clk) disable iff (rst)
      $rose(txo_frame) |-> txo_frame [*PKT_BYTES] ##1 !txo_frame)
   else
   begin
      assert_fails++;
      $error("txo_frame was not high for exactly one packet length");
   end

   // Ack hands the held packet over and starts the burst in the next cycle
   a_ack_access: assert property (@(posedge mi_clk) disable iff (rst)
      etx_ack |-> etx_access ##1 (txo_frame && !etx_access))
   else
   begin
      assert_fails++;
      $error("etx_ack did not start a burst and release the held packet");
   end

   a_one_pop: assert property (@(posedge mi_clk) disable iff (rst)
      $onehot0({txwr_pop, txrd_pop, txrr_pop}))
   else
   begin
      assert_fails++;
      $error("More than one queue popped in the same cycle");
   end

endmodule

bind etx etx_chk chk0 (.mi_clk, .rst, .txo_frame, .etx_ack, .etx_access,
                       .txwr_pop, .txrd_pop, .txrr_pop);

// ==== verif/etx_tb.sv ====
`timescale 1ns/1ps

module etx_tb import etx_pkg::*, etx_regs_pkg::*;
();

   localparam int BURST_TIMEOUT = 40;              // Cycles to wait for a frame

   logic        mi_clk, rst, mi_en, mi_we;
   logic [19:0] mi_addr;
   logic [31:0] mi_din, mi_dout;
   logic        txwr_access, txrd_access, txrr_access;
   etx_packet_t txwr_packet, txrd_packet, txrr_packet;
   logic        txwr_wait, txrd_wait, txrr_wait;
   logic        txi_wr_wait, txi_rd_wait, txo_frame;
   logic [7:0]  txo_data;
   logic [31:0] lfsr = 32'h2ead_84de;             // Random stream state
   logic [11:0] cur_chip_id = 12'h000;             // Mirror of reg_id
   int          mismatch_cnt = 0;
   int          other_cnt = 0;

   etx dut0 (.*);

   always #5 mi_clk = ~mi_clk;

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]}; // Taps 32,22,2,1
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic etx_packet_t rand_packet(input etx_cmd_t cmd);
      etx_packet_t p;
      p.cmd      = cmd;
      p.ctrlmode = rand_bits(4);
      p.dst_addr = rand_bits(32);
      p.data     = rand_bits(32);
      p.src_addr = rand_bits(32);
      if (p.dst_addr[ID_MSB:ID_LSB] == cur_chip_id)
         p.dst_addr[ID_LSB] = ~p.dst_addr[ID_LSB];  // Keep clear of the own ID
      return p;
   endfunction

   // Link byte order: header, then each word MSB first
   function automatic logic [7:0] expected_byte(input etx_packet_t p, input int idx);
      logic [7:0] b;
      if (idx == 0)
         b = {2'b00, p.cmd, p.ctrlmode};
      else if (idx <= 4)
         b = p.dst_addr[8*(4-idx) +: 8];
      else if (idx <= 8)
         b = p.data[8*(8-idx) +: 8];
      else
         b = p.src_addr[8*(12-idx) +: 8];
      return b;
   endfunction

   // Wait flag of the queue that takes this kind
   function automatic logic src_wait(input etx_cmd_t cmd);
      logic w;
      case (cmd)
         cmd_write: w = txwr_wait;
         cmd_read:  w = txrd_wait;
         default:   w = txrr_wait;
      endcase
      return w;
   endfunction

   task automatic cmp_byte(input logic [7:0] got, input logic [7:0] exp, input string name);
      if (got !== exp)
      begin
         mismatch_cnt++;
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic cmp_word(input logic [31:0] got, input logic [31:0] exp, input string name);
      if (got !== exp)
      begin
         mismatch_cnt++;
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic cmp_packet(input etx_packet_t got, input etx_packet_t exp, input string name);
      if (got !== exp)
      begin
         mismatch_cnt++;
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic cmp_bit(input logic got, input logic exp, input string name);
      if (got !== exp)
      begin
         mismatch_cnt++;
         $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic mi_write(input etx_reg_t r, input logic [31:0] d);
      @(negedge mi_clk);
      mi_en   = 1'b1;
      mi_we   = 1'b1;
      mi_addr = {16'h0, r, 2'b00};
      mi_din  = d;
      @(negedge mi_clk);
      mi_en   = 1'b0;
      mi_we   = 1'b0;
   endtask

   task automatic mi_read(input etx_reg_t r, output logic [31:0] d);
      @(negedge mi_clk);
      mi_en   = 1'b1;
      mi_addr = {16'h0, r, 2'b00};
      @(negedge mi_clk);
      mi_en   = 1'b0;
      d       = mi_dout;                           // Registered one edge after mi_en
   endtask

   task automatic send_packet(input etx_packet_t p);
      @(negedge mi_clk);
      case (p.cmd)
         cmd_write: txwr_access = 1'b1;
         cmd_read:  txrd_access = 1'b1;
         default:   txrr_access = 1'b1;
      endcase
      txwr_packet = p;
      txrd_packet = p;
      txrr_packet = p;
      @(negedge mi_clk);
      txwr_access = 1'b0;
      txrd_access = 1'b0;
      txrr_access = 1'b0;
   endtask

   task automatic expect_burst(input etx_packet_t exp);
      logic [7:0]  got [PKT_BYTES];
      etx_packet_t rebuilt;
      int          waited;
      waited = 0;
      @(negedge mi_clk);
      while (!txo_frame && waited < BURST_TIMEOUT)
      begin
         @(negedge mi_clk);
         waited++;
      end
      if (!txo_frame)
      begin
         other_cnt++;
         $display("No burst started within %0d cycles at %0t", BURST_TIMEOUT, $time);
      end
      else
      begin
         for (int i = 0; i < PKT_BYTES; i++)
         begin
            if (i > 0)
               @(negedge mi_clk);
            cmp_bit(txo_frame, 1'b1, $sformatf("txo_frame in byte %0d", i));
            got[i] = txo_data;
            cmp_byte(got[i], expected_byte(exp, i), $sformatf("txo_data byte %0d", i));
         end
         rebuilt.cmd      = etx_cmd_t'(got[0][5:4]);
         rebuilt.ctrlmode = got[0][3:0];
         rebuilt.dst_addr = {got[1], got[2], got[3], got[4]};
         rebuilt.data     = {got[5], got[6], got[7], got[8]};
         rebuilt.src_addr = {got[9], got[10], got[11], got[12]};
         cmp_packet(rebuilt, exp, "burst packet");
      end
   endtask

   task automatic expect_no_burst(input string what);
      int seen;
      seen = 0;
      for (int i = 0; i < BURST_TIMEOUT; i++)
      begin
         @(negedge mi_clk);
         if (txo_frame)
            seen = 1;
      end
      if (seen != 0)
      begin
         other_cnt++;
         $display("A %s addressed to this chip was sent at %0t", what, $time);
      end
   endtask

   task automatic test_registers();
      logic [31:0] d;
      mi_read(reg_status, d);
      cmp_word(d, 32'h0, "reg_status after reset");
      mi_write(reg_cfg, 32'hdead_beb1);
      mi_read(reg_cfg, d);
      cmp_word(d, 32'h0000_00b1, "reg_cfg");       // Only bits 7:4, 1, 0 kept
      mi_write(reg_id, 32'h1234_5abc);
      cur_chip_id = 12'habc;
      mi_read(reg_id, d);
      cmp_word(d, 32'h0000_0abc, "reg_id");
      mi_write(reg_cfg, 32'h0000_0001);            // Enable, no bypass
   endtask

   // Each kind held back up to its wait threshold, then released in one go
   task automatic test_format();
      etx_packet_t pkts [FIFO_AFULL];
      etx_cmd_t    cmd;
      for (int k = 0; k < 3; k++)
      begin
         cmd = etx_cmd_t'(k);
         @(negedge mi_clk);
         if (cmd == cmd_read)
            txi_rd_wait = 1'b1;
         else
            txi_wr_wait = 1'b1;                    // Also holds responses
         for (int j = 0; j < FIFO_AFULL; j++)
         begin
            pkts[j] = rand_packet(cmd);
            send_packet(pkts[j]);
            cmp_bit(src_wait(cmd), j + 1 >= FIFO_AFULL,
                    $sformatf("wait of kind %0d after %0d packets", k, j + 1));
         end
         @(negedge mi_clk);
         txi_rd_wait = 1'b0;
         txi_wr_wait = 1'b0;
         for (int j = 0; j < FIFO_AFULL; j++)
            expect_burst(pkts[j]);
         cmp_bit(src_wait(cmd), 1'b0, $sformatf("wait of kind %0d after drain", k));
      end
   endtask

   task automatic test_priority();
      etx_packet_t wp, rp, sp;
      mi_write(reg_cfg, 32'h0000_0000);
      wp = rand_packet(cmd_write);
      rp = rand_packet(cmd_read);
      sp = rand_packet(cmd_rresp);
      send_packet(wp);                             // Lowest priority loaded first
      send_packet(rp);
      send_packet(sp);
      mi_write(reg_cfg, 32'h0000_0001);
      expect_burst(sp);
      expect_burst(rp);
      expect_burst(wp);
   endtask

   task automatic test_id_filter();
      etx_packet_t p;
      p = rand_packet(cmd_write);
      p.dst_addr[ID_MSB:ID_LSB] = cur_chip_id;
      send_packet(p);
      expect_no_burst("write");
      p.cmd = cmd_read;
      send_packet(p);
      expect_no_burst("read");
      p.cmd = cmd_rresp;                           // Responses bypass the filter
      send_packet(p);
      expect_burst(p);
   endtask

   task automatic test_pushback();
      etx_packet_t wq [9];
      etx_packet_t rp;
      logic [31:0] d;
      @(negedge mi_clk);
      txi_rd_wait = 1'b1;
      rp = rand_packet(cmd_read);
      send_packet(rp);
      wq[0] = rand_packet(cmd_write);
      send_packet(wq[0]);
      expect_burst(wq[0]);                         // Write overtakes the held read
      @(negedge mi_clk);
      txi_rd_wait = 1'b0;
      expect_burst(rp);
      @(negedge mi_clk);
      txi_wr_wait = 1'b1;
      for (int n = 1; n <= 9; n++)
      begin
         wq[n-1] = rand_packet(cmd_write);
         send_packet(wq[n-1]);
         cmp_bit(txwr_wait, n >= FIFO_AFULL, $sformatf("txwr_wait after %0d writes", n));
      end
      mi_read(reg_status, d);
      cmp_word(d, 32'h0000_0009, "reg_status with txwr overflow"); // wr full, wr overflow
      mi_write(reg_status, 32'h0000_0038);
      mi_read(reg_status, d);
      cmp_word(d, 32'h0000_0001, "reg_status after clear");
      @(negedge mi_clk);
      txi_wr_wait = 1'b0;
      for (int j = 0; j < FIFO_DEPTH; j++)
         expect_burst(wq[j]);                      // Ninth was lost
      cmp_bit(txwr_wait, 1'b0, "txwr_wait after drain");
   endtask

   task automatic test_bypass();
      etx_packet_t p, exp;
      mi_write(reg_cfg, 32'h0000_0093);            // Enable, bypass, ctrlmode 9
      p = rand_packet(cmd_write);
      if (p.ctrlmode == 4'h9)
         p.ctrlmode = 4'h6;
      exp = p;
      exp.ctrlmode = 4'h9;
      send_packet(p);
      expect_burst(exp);
      mi_write(reg_cfg, 32'h0000_0001);
   endtask

   initial
   begin
      mi_clk      = 1'b0;
      rst         = 1'b1;
      mi_en       = 1'b0;
      mi_we       = 1'b0;
      mi_addr     = '0;
      mi_din      = '0;
      txwr_access = 1'b0;
      txrd_access = 1'b0;
      txrr_access = 1'b0;
      txwr_packet = '0;
      txrd_packet = '0;
      txrr_packet = '0;
      txi_wr_wait = 1'b0;
      txi_rd_wait = 1'b0;
      repeat (2) @(posedge mi_clk);
      @(negedge mi_clk);
      rst = 1'b0;
      test_registers();
      test_format();
      test_priority();
      test_id_filter();
      test_pushback();
      test_bypass();
      repeat (4) @(negedge mi_clk);
      other_cnt = other_cnt + dut0.chk0.assert_fails;
      $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
      if (mismatch_cnt == 0 && other_cnt == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

// ==== list.f ====
hdl/etx_pkg.sv
hdl/etx_regs_pkg.sv
hdl/etx_cfg.sv
hdl/etx_fifo.sv
hdl/etx_arbiter.sv
hdl/etx_protocol.sv
hdl/etx.sv
verif/etx_chk.sv
verif/etx_tb.sv
